// ==== Bender.yml ====
package:
  name: boot_soc

sources:
  - include_dirs:
      - design
    files:
      - design/socBusPkg.sv
      - design/bootPkg.sv
      - design/ramPortIf.sv
      - design/pacingTimer.sv
      - design/bootLoaderFsm.sv
      - design/programMemory.sv
      - design/ioBusBridge.sv
      - design/bootSoc.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tbClockGen.sv
      - testbench/bootSocChecker.sv
      - testbench/bootSocTb.sv

// ==== design/bootLoaderFsm.sv ====
`default_nettype none
`include "soc_settings.svh"

module bootLoaderFsm
    import bootPkg::*;
(
    input  logic                   CPUClock,
    input  logic                   rstN,
    input  logic                   restart,
    input  logic                   sdBusy,
    input  logic                   expired,
    input  logic [7:0]             sdData,
    output logic                   sdRead,
    output logic                   timerStart,
    output logic                   useHold,
    output logic                   bootActive,
    output logic [`DATA_WIDTH-1:0] sdAddress,
    ramPortIf.boot                 mem
);

    localparam int AddrBits = $clog2(`RAM_WORDS);

    bootState   state;
    logic       pending;
    logic       busySeen;
    logic       byteReady;
    logic       issue;
    logic [7:0] remaining;

    // A byte is there once busy has gone high and back low
    assign byteReady = pending && busySeen && !sdBusy;

    assign issue = !sdBusy && expired && !pending
                   && (state == requestLength || state == copyBytes);

    // Pace after each request, hold again on restart
    assign timerStart = issue || (state == running && restart);
    assign useHold    = (state == running);

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////
    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            state      <= holdReset;
            bootActive <= 1'b1;
            sdRead     <= 1'b0;
            sdAddress  <= '0;
            pending    <= 1'b0;
            busySeen   <= 1'b0;
            remaining  <= '0;
            mem.write  <= 1'b0;
        end else begin
            sdRead    <= issue;
            mem.write <= 1'b0;

            if (issue) begin
                pending  <= 1'b1;
                busySeen <= 1'b0;
            end else if (byteReady) begin
                pending <= 1'b0;
            end else if (pending && sdBusy) begin
                busySeen <= 1'b1;
            end

            case (state)
                holdReset: begin
                    sdAddress <= '0;
                    // Stay held while button 0 is still down
                    if (expired && !restart) begin
                        state <= requestLength;
                    end
                end
                requestLength: begin
                    if (issue) begin
                        state <= waitLength;
                    end
                end
                waitLength: begin
                    if (byteReady) begin
                        remaining <= sdData;
                        state     <= copyBytes;
                    end
                end
                copyBytes: begin
                    if (issue) begin
                        sdAddress <= sdAddress + 1'b1;
                    end
                    if (byteReady) begin
                        mem.write <= 1'b1;
                        if (remaining == '0) begin
                            state <= finish;
                        end else begin
                            remaining <= remaining - 1'b1;
                        end
                    end
                end
                finish: begin
                    bootActive <= 1'b0;
                    state      <= running;
                end
                running: begin
                    if (restart) begin
                        bootActive <= 1'b1;
                        state      <= holdReset;
                    end
                end
                default: state <= holdReset;
            endcase
        end
    end

    // Storage byte k+1 lands in word k
    always_ff @(posedge CPUClock) begin
        if (byteReady && state == copyBytes) begin
            mem.address   <= AddrBits'(sdAddress - 1'b1);
            mem.writeData <= {{(`DATA_WIDTH-8){1'b0}}, sdData};
        end
    end

    assert property (@(posedge CPUClock) disable iff (!rstN)
        sdRead |-> !sdBusy)
        else $error("sdRead issued while storage busy");

    // Length byte larger than the program memory
    assert property (@(posedge CPUClock) disable iff (!rstN)
        mem.write |-> sdAddress <= `RAM_WORDS)
        else $error("boot write beyond program memory");

endmodule

`default_nettype wire

// ==== design/bootPkg.sv ====
`default_nettype none

package bootPkg;

    typedef enum logic [2:0] {
        holdReset,
        requestLength,
        waitLength,
        copyBytes,
        finish,
        running
    } bootState;

endpackage

`default_nettype wire

// ==== design/bootSoc.sv ====
`default_nettype none
`include "soc_settings.svh"

module bootSoc
    import socBusPkg::*;
(
    input  logic                   CPUClock,
    input  logic                   rstN,
    input  logic                   sdBusy,
    input  logic [7:0]             sdData,
    input  logic [6:0]             btn,
    output logic                   sdRead,
    output logic [`DATA_WIDTH-1:0] sdAddress,
    output logic                   cpuReset,
    output logic [`DATA_WIDTH-1:0] cpuReadData,
    output logic                   cpuDone,
    output logic [7:0]             leds,
    output logic [7:0]             fbX,
    output logic [7:0]             fbY,
    output logic [7:0]             fbColor,
    output logic                   fbWrite1,
    output logic                   fbWrite2,
    output logic                   fbSelect,
    input  logic                   cpuRead,
    input  logic                   cpuWrite,
    input  logic [`DATA_WIDTH-1:0] cpuAddress,
    input  logic [`DATA_WIDTH-1:0] cpuWriteData
);

    fbWrite fbData;
    logic   timerStart;
    logic   useHold;
    logic   expired;

    ramPortIf bootPort ();
    ramPortIf cpuPort ();

    pacingTimer u_pacingTimer (
        .CPUClock (CPUClock),
        .rstN     (rstN),
        .start    (timerStart),
        .useHold  (useHold),
        .expired  (expired)
    );

    // CPU stays in reset for the whole load
    bootLoaderFsm u_bootLoaderFsm (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .restart    (~btn[0]),
        .sdBusy     (sdBusy),
        .expired    (expired),
        .sdData     (sdData),
        .sdRead     (sdRead),
        .timerStart (timerStart),
        .useHold    (useHold),
        .bootActive (cpuReset),
        .sdAddress  (sdAddress),
        .mem        (bootPort.boot)
    );

    programMemory u_programMemory (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .bootActive (cpuReset),
        .boot       (bootPort.memory),
        .cpu        (cpuPort.memory)
    );

    ioBusBridge u_ioBusBridge (
        .CPUClock     (CPUClock),
        .rstN         (rstN),
        .bootActive   (cpuReset),
        .cpuRead      (cpuRead),
        .cpuWrite     (cpuWrite),
        .cpuAddress   (cpuAddress),
        .cpuWriteData (cpuWriteData),
        .btn          (btn),
        .cpuReadData  (cpuReadData),
        .cpuDone      (cpuDone),
        .leds         (leds),
        .fbData       (fbData),
        .fbWrite1     (fbWrite1),
        .fbWrite2     (fbWrite2),
        .fbSelect     (fbSelect),
        .mem          (cpuPort.requester)
    );

    // Pixel record out to the framebuffer ports
    assign fbX     = fbData.x;
    assign fbY     = fbData.y;
    assign fbColor = fbData.color;

endmodule

`default_nettype wire

// ==== design/ioBusBridge.sv ====
`default_nettype none
`include "soc_settings.svh"

module ioBusBridge
    import socBusPkg::*;
(
    input  logic                   CPUClock,
    input  logic                   rstN,
    input  logic                   bootActive,
    input  logic                   cpuRead,
    input  logic                   cpuWrite,
    input  logic [`DATA_WIDTH-1:0] cpuAddress,
    input  logic [`DATA_WIDTH-1:0] cpuWriteData,
    input  logic [6:0]             btn,
    output logic [`DATA_WIDTH-1:0] cpuReadData,
    output logic                   cpuDone,
    output logic [7:0]             leds,
    output fbWrite                 fbData,
    output logic                   fbWrite1,
    output logic                   fbWrite2,
    output logic                   fbSelect,
    ramPortIf.requester            mem
);

    localparam int AddrBits = $clog2(`RAM_WORDS);

    cmdCode                   cmd;
    logic                     isMem;
    logic                     accept;
    logic                     cmdWrite;
    logic                     cmdRead;
    logic                     cmdDone;
    logic                     fbBusy;
    logic                     fbCmd;
    logic [`DATA_WIDTH-1:0]   cmdReadData;
    logic [6:1]               buttons;
    logic [`DEBOUNCE_BITS-1:0] lockout [6:1];

    assign cmd    = cmdCode'(cpuAddress[31:24]);
    assign isMem  = (cmd == none);
    // CPU strobes during boot are dropped
    assign accept = !bootActive;

    assign cmdWrite = accept && cpuWrite && !isMem;
    assign cmdRead  = accept && cpuRead && !isMem;
    assign fbBusy   = fbWrite1 || fbWrite2;
    assign fbCmd    = (cmd == socBusPkg::fbWrite1) || (cmd == socBusPkg::fbWrite2);

    assign mem.address   = cpuAddress[AddrBits-1:0];
    assign mem.writeData = cpuWriteData;
    assign mem.write     = accept && cpuWrite && isMem;
    assign mem.read      = accept && cpuRead && isMem;

    assign cpuDone     = mem.done || cmdDone;
    assign cpuReadData = cmdDone ? cmdReadData : mem.readData;

    ////////////////////////////////////////
    // Special commands
    ////////////////////////////////////////
    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            cmdDone  <= 1'b0;
            leds     <= '0;
            fbSelect <= 1'b0;
            fbWrite1 <= 1'b0;
            fbWrite2 <= 1'b0;
        end else begin
            cmdDone <= cmdWrite || cmdRead;
            if (cmdWrite) begin
                case (cmd)
                    ledLane0: leds <= cpuWriteData[7:0];
                    ledLane1: leds <= cpuWriteData[15:8];
                    ledLane2: leds <= cpuWriteData[23:16];
                    ledLane3: leds <= cpuWriteData[31:24];
                    fbSwap:   fbSelect <= !fbSelect;
                    default:  ;
                endcase
            end
            // One-cycle strobe, anything during it is lost
            if (fbBusy) begin
                fbWrite1 <= 1'b0;
                fbWrite2 <= 1'b0;
            end else begin
                fbWrite1 <= cmdWrite && (cmd == socBusPkg::fbWrite1);
                fbWrite2 <= cmdWrite && (cmd == socBusPkg::fbWrite2);
            end
        end
    end

    always_ff @(posedge CPUClock) begin
        if (cmdWrite && fbCmd && !fbBusy) begin
            fbData.x     <= cpuAddress[7:0];
            fbData.y     <= cpuAddress[15:8];
            fbData.color <= cpuWriteData[7:0];
        end
        if (cmdRead) begin
            cmdReadData <= (cmd == readButtons) ? {{(`DATA_WIDTH-6){1'b0}}, buttons} : '0;
        end
    end

    ////////////////////////////////////////
    // Button debounce, bit 0 goes to restart
    ////////////////////////////////////////
    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            buttons <= '0;
            for (int i = 1; i <= 6; i++) begin
                lockout[i] <= '0;
            end
        end else begin
            for (int i = 1; i <= 6; i++) begin
                if (lockout[i] == '0 && btn[i]) begin
                    buttons[i] <= 1'b1;
                    lockout[i] <= 1'b1;
                end else if (lockout[i] != '0) begin
                    // Runs until it wraps back to zero
                    lockout[i] <= lockout[i] + 1'b1;
                end else begin
                    buttons[i] <= 1'b0;
                end
            end
        end
    end

    // Every accepted strobe is answered, from memory or from here
    assert property (@(posedge CPUClock) disable iff (!rstN)
        (cpuRead || cpuWrite) && !bootActive |=> cpuDone)
        else $error("CPU strobe without cpuDone");

endmodule

`default_nettype wire

// ==== design/pacingTimer.sv ====
`default_nettype none
`include "soc_settings.svh"

module pacingTimer (
    input  logic CPUClock,
    input  logic rstN,
    input  logic start,
    input  logic useHold,
    output logic expired
);

    localparam int HoldCount = `RESET_HOLD_CYCLES;
    localparam int PaceCount = `PACE_CYCLES;
    localparam int MaxCount  = (HoldCount > PaceCount) ? HoldCount : PaceCount;
    localparam int CountBits = $clog2(MaxCount + 1);

    logic [CountBits-1:0] count;
    logic                 holdRunning;

    // Reset starts the hold interval by itself
    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            count       <= CountBits'(HoldCount);
            holdRunning <= 1'b1;
        end else if (start) begin
            count       <= useHold ? CountBits'(HoldCount) : CountBits'(PaceCount);
            holdRunning <= useHold;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end else begin
            holdRunning <= 1'b0;
        end
    end

    assign expired = (count == '0);

    // A new start must not cut a running hold interval short
    assert property (@(posedge CPUClock) disable iff (!rstN)
        start |-> !(holdRunning && !expired))
        else $error("pacingTimer restarted during hold interval");

endmodule

`default_nettype wire

// ==== design/programMemory.sv ====
`default_nettype none
`include "soc_settings.svh"

module programMemory (
    input  logic      CPUClock,
    input  logic      rstN,
    input  logic      bootActive,
    ramPortIf.memory  boot,
    ramPortIf.memory  cpu
);

    logic [`DATA_WIDTH-1:0] words [`RAM_WORDS];
    logic [`DATA_WIDTH-1:0] readReg;

    // Boot port owns the array until loading ends
    always_ff @(posedge CPUClock) begin
        if (bootActive) begin
            if (boot.write) begin
                words[boot.address] <= boot.writeData;
            end
        end else if (cpu.write) begin
            words[cpu.address] <= cpu.writeData;
        end else if (cpu.read) begin
            readReg <= words[cpu.address];
        end
    end

    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            boot.done <= 1'b0;
            cpu.done  <= 1'b0;
        end else begin
            boot.done <= bootActive && boot.write;
            cpu.done  <= !bootActive && (cpu.read || cpu.write);
        end
    end

    assign boot.readData = readReg;
    assign cpu.readData  = readReg;

endmodule

`default_nettype wire

// ==== design/ramPortIf.sv ====
`default_nettype none
`include "soc_settings.svh"

interface ramPortIf;

    localparam int AddrBits = $clog2(`RAM_WORDS);

    logic [AddrBits-1:0]    address;
    logic [`DATA_WIDTH-1:0] writeData;
    logic                   write;
    logic                   read;
    logic [`DATA_WIDTH-1:0] readData;
    logic                   done;

    // Loader only writes
    modport boot (output address, writeData, write);

    modport requester (
        output address, writeData, write, read,
        input  readData, done
    );

    modport memory (
        input  address, writeData, write, read,
        output readData, done
    );

endinterface

`default_nettype wire

// ==== design/socBusPkg.sv ====
`default_nettype none

package socBusPkg;

    // Special commands live in address bits 31..24
    typedef enum logic [7:0] {
        none        = 8'd0,
        ledLane0    = 8'd1,
        ledLane1    = 8'd2,
        ledLane2    = 8'd3,
        ledLane3    = 8'd4,
        fbWrite1    = 8'd5,
        fbWrite2    = 8'd6,
        fbSwap      = 8'd7,
        readButtons = 8'd8
    } cmdCode;

    // One pixel for a framebuffer
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] color;
    } fbWrite;

endpackage

`default_nettype wire

// ==== design/soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Program memory depth in 32-bit words
`define RAM_WORDS 256

// Hold time after reset or restart, before the first storage request
`define RESET_HOLD_CYCLES 16

// The storage reader loses bytes if requests come faster than this
`define PACE_CYCLES 8

// Lockout counter per button, short for simulation
`define DEBOUNCE_BITS 4

// CPU word
`define DATA_WIDTH 32

`endif

// ==== files.f ====
+incdir+design
design/socBusPkg.sv
design/bootPkg.sv
design/ramPortIf.sv
design/pacingTimer.sv
design/bootLoaderFsm.sv
design/programMemory.sv
design/ioBusBridge.sv
design/bootSoc.sv
testbench/tbClockGen.sv
testbench/bootSocChecker.sv
testbench/bootSocTb.sv

// ==== testbench/bootSocChecker.sv ====
`default_nettype none
`include "soc_settings.svh"

module bootSocChecker
    import socBusPkg::*;
#(
    parameter int BytesPerBoot  = 7,
    parameter int ExpectedBoots = 2
) (
    input  logic        CPUClock,
    input  logic        rstN,
    input  logic        runDone,
    input  logic [31:0] expectValue,
    input  logic        sdRead,
    input  logic [31:0] sdAddress,
    input  logic        sdBusy,
    input  logic        cpuReset,
    input  logic        cpuRead,
    input  logic        cpuWrite,
    input  logic [31:0] cpuAddress,
    input  logic [31:0] cpuReadData,
    input  logic        cpuDone,
    input  logic [7:0]  leds,
    input  logic [7:0]  fbX,
    input  logic [7:0]  fbY,
    input  logic [7:0]  fbColor,
    input  logic        fbWrite1,
    input  logic        fbWrite2,
    input  logic        fbSelect,
    output int          errorCount
);

    int          mismatchCount = 0;
    int          failureCount  = 0;
    int          checkCount    = 0;
    int          bootsDone     = 0;
    int          holdCycles;
    int          paceGap;
    int          readsThisBoot;
    logic        prevCpuReset;
    logic        pending;
    logic        pendingRead;
    logic        fbFollow;
    cmdCode      pendingCmd;
    logic [31:0] pendingExpect;

    assign errorCount = mismatchCount + failureCount;

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        mismatchCount++;
        $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic reportFailure(input string what);
        failureCount++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    always @(posedge CPUClock) begin
        if (!rstN) begin
            holdCycles    = 0;
            paceGap       = 0;
            readsThisBoot = 0;
            prevCpuReset  = 1'b1;
            pending       = 1'b0;
            fbFollow      = 1'b0;
        end else begin
            ////////////////////////////////////////
            // Boot sequence
            ////////////////////////////////////////
            if (cpuReset && !prevCpuReset) begin
                holdCycles    = 0;
                readsThisBoot = 0;
            end else begin
                holdCycles++;
            end
            paceGap++;
            if (sdRead) begin
                if (sdBusy) begin
                    reportFailure("sdRead issued while sdBusy is high");
                end
                if (readsThisBoot == 0 && holdCycles < `RESET_HOLD_CYCLES) begin
                    reportFailure($sformatf("first sdRead came %0d cycles after reset",
                                            holdCycles));
                end
                if (readsThisBoot != 0 && paceGap < `PACE_CYCLES) begin
                    reportFailure($sformatf("two sdRead strobes only %0d cycles apart",
                                            paceGap));
                end
                // Bytes are fetched in storage order from index 0
                if (sdAddress !== 32'(readsThisBoot)) begin
                    reportMismatch("sdAddress", sdAddress, 32'(readsThisBoot));
                end
                readsThisBoot++;
                paceGap = 0;
            end
            if (!cpuReset && prevCpuReset) begin
                bootsDone++;
                if (readsThisBoot != BytesPerBoot) begin
                    reportFailure($sformatf("cpuReset released after %0d storage reads, not %0d",
                                            readsThisBoot, BytesPerBoot));
                end
            end
            prevCpuReset = cpuReset;

            ////////////////////////////////////////
            // CPU answers
            ////////////////////////////////////////
            if (fbFollow) begin
                fbFollow = 1'b0;
                if (fbWrite1 || fbWrite2) begin
                    reportFailure("framebuffer strobe lasted more than one cycle");
                end
            end
            if (pending) begin
                pending = 1'b0;
                if (!cpuDone) begin
                    reportFailure("no cpuDone one cycle after a CPU strobe");
                end else begin
                    case (pendingCmd)
                        none: begin
                            if (pendingRead && cpuReadData !== pendingExpect) begin
                                reportMismatch("memory read data", cpuReadData, pendingExpect);
                            end
                        end
                        ledLane0, ledLane1, ledLane2, ledLane3: begin
                            if (leds !== pendingExpect[7:0]) begin
                                reportMismatch("leds", {24'h0, leds}, pendingExpect);
                            end
                        end
                        socBusPkg::fbWrite1, socBusPkg::fbWrite2: begin
                            fbFollow = 1'b1;
                            if (fbWrite1 !== (pendingCmd == socBusPkg::fbWrite1) ||
                                fbWrite2 !== (pendingCmd == socBusPkg::fbWrite2)) begin
                                reportFailure("wrong framebuffer strobe after pixel command");
                            end
                            if ({fbX, fbY, fbColor} !== pendingExpect[23:0]) begin
                                reportMismatch("pixel x/y/color", {8'h0, fbX, fbY, fbColor},
                                               pendingExpect);
                            end
                        end
                        fbSwap: begin
                            if (fbSelect !== pendingExpect[0]) begin
                                reportMismatch("fbSelect", {31'h0, fbSelect}, pendingExpect);
                            end
                        end
                        readButtons: begin
                            if (cpuReadData !== pendingExpect) begin
                                reportMismatch("button read data", cpuReadData, pendingExpect);
                            end
                        end
                        default: ;
                    endcase
                end
            end else if (cpuDone) begin
                reportFailure("cpuDone without a CPU strobe");
            end
            // Strobes during boot are dropped
            if ((cpuRead || cpuWrite) && !cpuReset) begin
                pending       = 1'b1;
                pendingRead   = cpuRead;
                pendingCmd    = cmdCode'(cpuAddress[31:24]);
                pendingExpect = expectValue;
                checkCount++;
            end
        end
    end

    always @(posedge runDone) begin
        if (bootsDone != ExpectedBoots) begin
            reportFailure($sformatf("%0d boots completed, expected %0d",
                                    bootsDone, ExpectedBoots));
        end
        $display("Checker: %0d CPU accesses, %0d mismatches, %0d other errors",
                 checkCount, mismatchCount, failureCount);
    end

endmodule

`default_nettype wire

// ==== testbench/bootSocTb.sv ====
`default_nettype none
`include "soc_settings.svh"

module bootSocTb;

    localparam int ProgramLength  = 5;
    localparam int ImageBytes     = ProgramLength + 2;
    localparam int RereadSteps    = ProgramLength + 1;
    localparam int NumSteps       = 23;
    localparam int MaxDelay       = 6;
    localparam int BootCycles     = `RESET_HOLD_CYCLES
                                    + ImageBytes * (`PACE_CYCLES + MaxDelay);
    localparam int WatchdogCycles = 2 * BootCycles + 20 * (NumSteps + RereadSteps) + 200;

    typedef enum logic [1:0] {
        rdOp,
        wrOp,
        btnOp
    } opKind;

    typedef struct packed {
        opKind       op;
        logic [31:0] address;
        logic [31:0] data;
        logic [31:0] expected;
    } stepRow;

    logic        CPUClock;
    logic        rstN;
    logic        sdBusy;
    logic [7:0]  sdData;
    logic [6:0]  btn;
    logic        sdRead;
    logic [31:0] sdAddress;
    logic        cpuReset;
    logic [31:0] cpuReadData;
    logic        cpuDone;
    logic [7:0]  leds;
    logic [7:0]  fbX;
    logic [7:0]  fbY;
    logic [7:0]  fbColor;
    logic        fbWrite1;
    logic        fbWrite2;
    logic        fbSelect;
    logic        cpuRead;
    logic        cpuWrite;
    logic [31:0] cpuAddress;
    logic [31:0] cpuWriteData;
    logic [31:0] expectValue;
    logic        runDone;
    int          errorCount;

    logic [7:0]  storage [ImageBytes];
    int unsigned replyDelay [64];
    stepRow      steps [NumSteps];

    tbClockGen u_clockGen (
        .CPUClock (CPUClock),
        .rstN     (rstN)
    );

    bootSoc u_bootSoc (
        .CPUClock     (CPUClock),
        .rstN         (rstN),
        .sdBusy       (sdBusy),
        .sdData       (sdData),
        .btn          (btn),
        .sdRead       (sdRead),
        .sdAddress    (sdAddress),
        .cpuReset     (cpuReset),
        .cpuReadData  (cpuReadData),
        .cpuDone      (cpuDone),
        .leds         (leds),
        .fbX          (fbX),
        .fbY          (fbY),
        .fbColor      (fbColor),
        .fbWrite1     (fbWrite1),
        .fbWrite2     (fbWrite2),
        .fbSelect     (fbSelect),
        .cpuRead      (cpuRead),
        .cpuWrite     (cpuWrite),
        .cpuAddress   (cpuAddress),
        .cpuWriteData (cpuWriteData)
    );

    bootSocChecker #(
        .BytesPerBoot  (ImageBytes),
        .ExpectedBoots (2)
    ) u_checker (
        .CPUClock    (CPUClock),
        .rstN        (rstN),
        .runDone     (runDone),
        .expectValue (expectValue),
        .sdRead      (sdRead),
        .sdAddress   (sdAddress),
        .sdBusy      (sdBusy),
        .cpuReset    (cpuReset),
        .cpuRead     (cpuRead),
        .cpuWrite    (cpuWrite),
        .cpuAddress  (cpuAddress),
        .cpuReadData (cpuReadData),
        .cpuDone     (cpuDone),
        .leds        (leds),
        .fbX         (fbX),
        .fbY         (fbY),
        .fbColor     (fbColor),
        .fbWrite1    (fbWrite1),
        .fbWrite2    (fbWrite2),
        .fbSelect    (fbSelect),
        .errorCount  (errorCount)
    );

    task automatic setStep(input int idx, input opKind op, input logic [31:0] address,
                           input logic [31:0] data, input logic [31:0] expected);
        steps[idx].op       = op;
        steps[idx].address  = address;
        steps[idx].data     = data;
        steps[idx].expected = expected;
    endtask

    // Rows 0..5 read back the program, so they are reused after the restart
    task automatic buildTable();
        int k;
        for (k = 0; k < RereadSteps; k++) begin
            setStep(k, rdOp, 32'(k), 32'h0, {24'h0, storage[k + 1]});
        end
        setStep(6,  wrOp,  32'h0000_0009, 32'hDEAD_BEEF, 32'h0);
        setStep(7,  rdOp,  32'h0000_0009, 32'h0,         32'hDEAD_BEEF);
        setStep(8,  wrOp,  32'h0000_0002, 32'h1234_5678, 32'h0);
        setStep(9,  rdOp,  32'h0000_0002, 32'h0,         32'h1234_5678);
        // LED lanes, low address bits point at words in use
        setStep(10, wrOp,  32'h0100_0002, 32'hA1B2_C3D4, 32'h0000_00D4);
        setStep(11, wrOp,  32'h0200_0002, 32'hA1B2_C3D4, 32'h0000_00C3);
        setStep(12, wrOp,  32'h0300_0009, 32'hA1B2_C3D4, 32'h0000_00B2);
        setStep(13, wrOp,  32'h0400_0009, 32'hA1B2_C3D4, 32'h0000_00A1);
        setStep(14, rdOp,  32'h0000_0002, 32'h0,         32'h1234_5678);
        setStep(15, rdOp,  32'h0000_0009, 32'h0,         32'hDEAD_BEEF);
        // Expected pixel packed as x, y, color
        setStep(16, wrOp,  32'h0500_3412, 32'h0000_0077, 32'h0012_3477);
        setStep(17, wrOp,  32'h0600_569A, 32'h0000_003C, 32'h009A_563C);
        setStep(18, wrOp,  32'h0700_0000, 32'h0,         32'h0000_0001);
        setStep(19, wrOp,  32'h0700_0000, 32'h0,         32'h0000_0000);
        setStep(20, rdOp,  32'h0800_0000, 32'h0,         32'h0000_0000);
        setStep(21, btnOp, 32'h0,         32'h0000_0055, 32'h0);
        setStep(22, rdOp,  32'h0800_0000, 32'h0,         32'h0000_002A);
    endtask

    task automatic applyStep(input stepRow row);
        int waitCycles;
        @(posedge CPUClock);
        if (row.op == btnOp) begin
            btn <= row.data[6:0];
            repeat (4) @(posedge CPUClock);
        end else begin
            cpuRead      <= (row.op == rdOp);
            cpuWrite     <= (row.op == wrOp);
            cpuAddress   <= row.address;
            cpuWriteData <= row.data;
            expectValue  <= row.expected;
            @(posedge CPUClock);
            cpuRead  <= 1'b0;
            cpuWrite <= 1'b0;
            waitCycles = 0;
            while (!cpuDone && waitCycles < 4) begin
                @(posedge CPUClock);
                waitCycles++;
            end
            // Room for the framebuffer strobe to drop
            repeat (2) @(posedge CPUClock);
        end
    endtask

    task automatic waitBootDone();
        while (cpuReset) begin
            @(posedge CPUClock);
        end
        repeat (2) @(posedge CPUClock);
    endtask

    task automatic endRun(input bit timedOut);
        runDone = 1'b1;
        #1;
        if (timedOut || errorCount != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Storage reader model
    ////////////////////////////////////////
    initial begin : storageModel
        int replyIndex;
        int byteIndex;
        sdBusy     = 1'b0;
        sdData     = 8'h00;
        replyIndex = 0;
        forever begin
            @(posedge CPUClock);
            if (rstN && sdRead) begin
                byteIndex = int'(sdAddress);
                sdBusy <= 1'b1;
                repeat (replyDelay[replyIndex % 64]) @(posedge CPUClock);
                replyIndex++;
                sdData <= (byteIndex < ImageBytes) ? storage[byteIndex] : 8'h00;
                sdBusy <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WatchdogCycles) @(posedge CPUClock);
        $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
        endRun(1'b1);
    end

    initial begin : mainFlow
        int k;
        cpuRead      = 1'b0;
        cpuWrite     = 1'b0;
        cpuAddress   = 32'h0;
        cpuWriteData = 32'h0;
        expectValue  = 32'h0;
        btn          = 7'b000_0001;
        runDone      = 1'b0;

        void'($urandom(32'h933f9685));
        storage[0] = 8'(ProgramLength);
        for (k = 1; k < ImageBytes; k++) begin
            storage[k] = 8'($urandom());
        end
        for (k = 0; k < 64; k++) begin
            replyDelay[k] = 1 + ($urandom() % MaxDelay);
        end
        buildTable();

        @(posedge rstN);
        waitBootDone();
        for (k = 0; k < NumSteps; k++) begin
            applyStep(steps[k]);
        end

        // Button 0 low restarts the load, word 2 comes back from storage
        @(posedge CPUClock);
        btn <= 7'b000_0000;
        while (!cpuReset) begin
            @(posedge CPUClock);
        end
        repeat (3) @(posedge CPUClock);
        btn <= 7'b000_0001;
        waitBootDone();
        for (k = 0; k < RereadSteps; k++) begin
            applyStep(steps[k]);
        end

        repeat (4) @(posedge CPUClock);
        endRun(1'b0);
    end

endmodule

`default_nettype wire

// ==== testbench/tbClockGen.sv ====
`default_nettype none

module tbClockGen (
    output logic CPUClock,
    output logic rstN
);

    // 10 time unit period
    initial begin
        CPUClock = 1'b0;
        forever #5 CPUClock = ~CPUClock;
    end

    // Reset held for three rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge CPUClock);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire
